// ==== Makefile ====
TOP = tb_board_config

all: run

build:
	verilator --binary --timing --assert -j 0 -f all.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^sim passed$$"

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

// ==== all.f ====
source/board_cfg_pkg.sv
source/board_feature_table.sv
source/board_memory_map.sv
source/board_config.sv
test/tb_clock.sv
test/tb_board_config.sv

// ==== source/board_cfg_pkg.sv ====
`default_nettype none

package board_cfg_pkg;

    // boards without a row still need a game code
    typedef enum logic [5:0] {
        GAME_FINALB    = 6'd0,
        GAME_DONDOKOD  = 6'd1,
        GAME_MEGAB     = 6'd2,
        GAME_THUNDFOX  = 6'd3,
        GAME_CAMELTRY  = 6'd4,
        GAME_QTORIMON  = 6'd5,
        GAME_LIQUIDK   = 6'd6,
        GAME_QUIZHQ    = 6'd7,
        GAME_SSI       = 6'd8,
        GAME_GUNFRONT  = 6'd9,
        GAME_GROWL     = 6'd10,
        GAME_MJNQUEST  = 6'd11,
        GAME_FOOTCHMP  = 6'd12,
        GAME_KOSHIEN   = 6'd13,
        GAME_YUYUGOGO  = 6'd14,
        GAME_NINJAK    = 6'd15,
        GAME_SOLFIGTR  = 6'd16,
        GAME_QZQUEST   = 6'd17,
        GAME_PULIRULA  = 6'd18,
        GAME_METALB    = 6'd19,
        GAME_QZCHIKYU  = 6'd20,
        GAME_YESNOJ    = 6'd21,
        GAME_DEADCONX  = 6'd22,
        GAME_DINOREX   = 6'd23,
        GAME_QJINSEI   = 6'd24,
        GAME_QCRAYON   = 6'd25,
        GAME_QCRAYON2  = 6'd26,
        GAME_DRIFTOUT  = 6'd27,
        GAME_DEADCONXJ = 6'd28
    } game_t;

    localparam int REGION_COUNT = 15; // cpu address regions per board

    typedef enum logic [3:0] {
        REGION_ROM       = 4'd0,
        REGION_ROM1      = 4'd1,
        REGION_EXTRA_ROM = 4'd2,
        REGION_WORK_RAM  = 4'd3,
        REGION_SCREEN0   = 4'd4,  // tc0100scn
        REGION_SCREEN1   = 4'd5,  // second scn or tc0480scp
        REGION_OBJ       = 4'd6,
        REGION_COLOR     = 4'd7,  // palette ram or pcr
        REGION_IO0       = 4'd8,
        REGION_IO1       = 4'd9,
        REGION_SOUND     = 4'd10, // tc0140syt
        REGION_EXTENSION = 4'd11,
        REGION_PRIORITY  = 4'd12, // tc0360pri
        REGION_ROZ       = 4'd13, // grd or grw ram
        REGION_CCHIP     = 4'd14
    } region_t;

    // base is a[23:16] and mask picks which of those bits must match
    typedef struct packed {
        logic [7:0] base;
        logic [7:0] mask;
    } map_entry_t;

    typedef map_entry_t [REGION_COUNT-1:0] region_map_t; // index with region_t

    localparam map_entry_t REGION_UNMAPPED = '{8'hff, 8'h00}; // nothing decodes

    typedef struct packed {
        logic       pri_high;     // 360pri high priority mode
        logic       pri;          // tc0360pri fitted
        logic       dar_acc;
        logic       dar;          // tc0260dar palette dac
        logic       pcr;          // tc0110pcr palette
        logic       fmc;          // tc0190fmc
        logic [1:0] obj_extender;
        logic       io_82c265;
        logic       io_te7750;
        logic       io_swap;
        logic       grd;          // tc0280grd roz
        logic       grw;          // tc0430grw roz
        logic       scp;          // tc0480scp tilemap
        logic       scn;          // tc0100scn tilemap
        logic       bpp15;
        logic       bppmix;
    } feature_fields_t;

    // same 17 bits seen as a table word or as chip flags
    typedef union packed {
        logic [16:0]     raw;
        feature_fields_t fields;
    } feature_row_u;

    localparam feature_row_u FEATURE_DEFAULT = 17'b00_00_1_0_00_0_0_0_0_0_0_0_0_0; // pcr only

endpackage

`default_nettype wire

// ==== source/board_config.sv ====
`default_nettype none

module board_config (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire board_cfg_pkg::game_t game,

    output logic                      cfg_360pri,
    output logic                      cfg_360pri_high,
    output logic                      cfg_110pcr,
    output logic                      cfg_260dar,
    output logic                      cfg_260dar_acc,
    output logic                      cfg_190fmc,
    output logic [1:0]                cfg_obj_extender,
    output logic                      cfg_io_swap,
    output logic                      cfg_tmp82c265,
    output logic                      cfg_te7750,
    output logic                      cfg_280grd,
    output logic                      cfg_430grw,
    output logic                      cfg_480scp,
    output logic                      cfg_100scn,
    output logic                      cfg_bpp15,
    output logic                      cfg_bppmix,

    output logic [15:0]               cfg_addr_rom,
    output logic [15:0]               cfg_addr_rom1,
    output logic [15:0]               cfg_addr_extra_rom,
    output logic [15:0]               cfg_addr_work_ram,
    output logic [15:0]               cfg_addr_screen0,
    output logic [15:0]               cfg_addr_screen1,
    output logic [15:0]               cfg_addr_obj,
    output logic [15:0]               cfg_addr_color,
    output logic [15:0]               cfg_addr_io0,
    output logic [15:0]               cfg_addr_io1,
    output logic [15:0]               cfg_addr_sound,
    output logic [15:0]               cfg_addr_extension,
    output logic [15:0]               cfg_addr_priority,
    output logic [15:0]               cfg_addr_roz,
    output logic [15:0]               cfg_addr_cchip
);

    import board_cfg_pkg::*;

    feature_row_u features; // registered chip flags
    region_map_t  regions;  // registered map, one entry per region

    board_feature_table u_feature_table (
        .clk      (clk),
        .reset    (reset),
        .game     (game),
        .features (features)
    );

    board_memory_map u_memory_map (
        .clk     (clk),
        .reset   (reset),
        .game    (game),
        .regions (regions)
    );

    assign cfg_360pri_high  = features.fields.pri_high;
    assign cfg_360pri       = features.fields.pri;
    assign cfg_260dar_acc   = features.fields.dar_acc;
    assign cfg_260dar       = features.fields.dar;
    assign cfg_110pcr       = features.fields.pcr;
    assign cfg_190fmc       = features.fields.fmc;
    assign cfg_obj_extender = features.fields.obj_extender;
    assign cfg_tmp82c265    = features.fields.io_82c265;
    assign cfg_te7750       = features.fields.io_te7750;
    assign cfg_io_swap      = features.fields.io_swap;
    assign cfg_280grd       = features.fields.grd;
    assign cfg_430grw       = features.fields.grw;
    assign cfg_480scp       = features.fields.scp;
    assign cfg_100scn       = features.fields.scn;
    assign cfg_bpp15        = features.fields.bpp15;
    assign cfg_bppmix       = features.fields.bppmix;

    // each entry leaves as {base, mask}
    assign cfg_addr_rom       = regions[REGION_ROM];
    assign cfg_addr_rom1      = regions[REGION_ROM1];
    assign cfg_addr_extra_rom = regions[REGION_EXTRA_ROM];
    assign cfg_addr_work_ram  = regions[REGION_WORK_RAM];
    assign cfg_addr_screen0   = regions[REGION_SCREEN0];
    assign cfg_addr_screen1   = regions[REGION_SCREEN1];
    assign cfg_addr_obj       = regions[REGION_OBJ];
    assign cfg_addr_color     = regions[REGION_COLOR];
    assign cfg_addr_io0       = regions[REGION_IO0];
    assign cfg_addr_io1       = regions[REGION_IO1];
    assign cfg_addr_sound     = regions[REGION_SOUND];
    assign cfg_addr_extension = regions[REGION_EXTENSION];
    assign cfg_addr_priority  = regions[REGION_PRIORITY];
    assign cfg_addr_roz       = regions[REGION_ROZ];
    assign cfg_addr_cchip     = regions[REGION_CCHIP];

endmodule

`default_nettype wire

// ==== source/board_feature_table.sv ====
`default_nettype none

module board_feature_table (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire board_cfg_pkg::game_t   game,
    output board_cfg_pkg::feature_row_u features
);

    import board_cfg_pkg::*;

    feature_row_u row; // combinational lookup

    // column order pri_high pri | dar_acc dar | pcr | fmc | objx | 265 7750 swap |
    //          grd grw scp scn | bpp15 bppmix
    always_comb begin
        case (game)
            GAME_FINALB:    row.raw = 17'b00_00_1_0_00_0_0_0_0_0_0_0_0_0;
            GAME_DONDOKOD:  row.raw = 17'b01_01_0_0_00_0_0_0_1_0_0_0_0_0; // grd roz
            GAME_MEGAB:     row.raw = 17'b01_01_0_0_00_0_0_0_0_0_0_0_1_1;
            GAME_THUNDFOX:  row.raw = 17'b11_11_0_0_00_0_0_0_0_0_0_1_0_0; // two scn
            GAME_CAMELTRY:  row.raw = 17'b01_01_0_0_00_0_0_0_1_0_0_0_0_0;
            GAME_GROWL:     row.raw = 17'b01_01_0_1_00_1_0_0_0_0_0_0_1_1;
            GAME_FOOTCHMP:  row.raw = 17'b01_11_0_1_00_0_1_0_0_0_1_0_0_0; // scp, te7750
            GAME_YUYUGOGO:  row.raw = 17'b00_01_0_0_01_0_0_0_0_0_0_0_0_0;
            GAME_PULIRULA:  row.raw = 17'b11_01_0_0_10_0_0_0_0_1_0_0_1_0; // grw roz
            GAME_METALB:    row.raw = 17'b01_11_0_0_00_0_0_1_0_0_1_0_1_1;
            GAME_DINOREX:   row.raw = 17'b01_01_0_0_01_0_0_0_0_0_0_0_1_1;
            GAME_DEADCONX,
            GAME_DEADCONXJ: row.raw = 17'b01_11_0_1_00_0_1_0_0_0_1_0_1_1; // same board
            default:        row     = FEATURE_DEFAULT; // unknown board
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            features <= FEATURE_DEFAULT;
        end else begin
            features <= row; // one cycle behind game
        end
    end

    // no board fits a third extender mode
    assert property (@(posedge clk) disable iff (reset)
        features.fields.obj_extender != 2'd3)
        else $error("obj_extender 3 on game %0d", $past(game));

    // mixed depth only exists on top of 15 bpp
    assert property (@(posedge clk) features.fields.bppmix |-> features.fields.bpp15)
        else $error("bppmix without bpp15 on game %0d", $past(game));

endmodule

`default_nettype wire

// ==== source/board_memory_map.sv ====
`default_nettype none

module board_memory_map (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire board_cfg_pkg::game_t  game,
    output board_cfg_pkg::region_map_t regions
);

    import board_cfg_pkg::*;

    region_map_t next_map;    // lookup result
    logic        board_known; // game has its own map

    always_comb begin
        next_map    = {REGION_COUNT{REGION_UNMAPPED}}; // all off, then fill in
        board_known = 1'b1;
        case (game)
            GAME_FINALB: begin
                next_map[REGION_ROM]       = '{8'h00, 8'hfc}; // 256k
                next_map[REGION_WORK_RAM]  = '{8'h10, 8'hff};
                next_map[REGION_COLOR]     = '{8'h20, 8'hff}; // pcr regs
                next_map[REGION_IO0]       = '{8'h30, 8'hff}; // tc0220ioc
                next_map[REGION_SOUND]     = '{8'h32, 8'hff};
                next_map[REGION_SCREEN0]   = '{8'h80, 8'hf0};
                next_map[REGION_OBJ]       = '{8'h90, 8'hff};
            end
            GAME_DONDOKOD: begin
                next_map[REGION_ROM]       = '{8'h00, 8'hf8}; // 512k
                next_map[REGION_WORK_RAM]  = '{8'h10, 8'hff};
                next_map[REGION_COLOR]     = '{8'h20, 8'hff};
                next_map[REGION_IO0]       = '{8'h30, 8'hff};
                next_map[REGION_SOUND]     = '{8'h32, 8'hff};
                next_map[REGION_SCREEN0]   = '{8'h80, 8'hf0};
                next_map[REGION_OBJ]       = '{8'h90, 8'hff};
                next_map[REGION_ROZ]       = '{8'ha0, 8'hfe}; // grd ram
                next_map[REGION_PRIORITY]  = '{8'hb0, 8'hff};
            end
            GAME_MEGAB: begin
                next_map[REGION_ROM]       = '{8'h00, 8'hf8};
                next_map[REGION_SOUND]     = '{8'h10, 8'hff};
                next_map[REGION_IO0]       = '{8'h12, 8'hff};
                next_map[REGION_CCHIP]     = '{8'h18, 8'hff}; // c-chip shared ram
                next_map[REGION_WORK_RAM]  = '{8'h20, 8'hff};
                next_map[REGION_COLOR]     = '{8'h30, 8'hff};
                next_map[REGION_PRIORITY]  = '{8'h40, 8'hff};
                next_map[REGION_SCREEN0]   = '{8'h60, 8'hf1}; // 61xxxx not decoded
                next_map[REGION_OBJ]       = '{8'h80, 8'hff};
            end
            GAME_THUNDFOX: begin
                next_map[REGION_ROM]       = '{8'h00, 8'hf8};
                next_map[REGION_COLOR]     = '{8'h10, 8'hfe};
                next_map[REGION_IO0]       = '{8'h20, 8'hff};
                next_map[REGION_SOUND]     = '{8'h22, 8'hff};
                next_map[REGION_WORK_RAM]  = '{8'h30, 8'hff};
                next_map[REGION_SCREEN0]   = '{8'h40, 8'hf0}; // scn 0
                next_map[REGION_SCREEN1]   = '{8'h50, 8'hf0}; // scn 1
                next_map[REGION_OBJ]       = '{8'h60, 8'hff};
                next_map[REGION_PRIORITY]  = '{8'h80, 8'hff};
            end
            GAME_CAMELTRY: begin
                next_map[REGION_ROM]       = '{8'h00, 8'hfc};
                next_map[REGION_WORK_RAM]  = '{8'h10, 8'hff};
                next_map[REGION_COLOR]     = '{8'h20, 8'hff};
                next_map[REGION_IO0]       = '{8'h30, 8'hff}; // paddle shares this base
                next_map[REGION_SOUND]     = '{8'h32, 8'hff};
                next_map[REGION_SCREEN0]   = '{8'h80, 8'hf0};
                next_map[REGION_OBJ]       = '{8'h90, 8'hff};
                next_map[REGION_ROZ]       = '{8'ha0, 8'hff};
                next_map[REGION_PRIORITY]  = '{8'hd0, 8'hff};
            end
            GAME_GROWL: begin
                next_map[REGION_ROM]       = '{8'h00, 8'hf0}; // 1m
                next_map[REGION_WORK_RAM]  = '{8'h10, 8'hff};
                next_map[REGION_COLOR]     = '{8'h20, 8'hff};
                next_map[REGION_IO0]       = '{8'h30, 8'hff}; // dsw and coin
                next_map[REGION_IO1]       = '{8'h32, 8'hff}; // inputs
                next_map[REGION_SOUND]     = '{8'h40, 8'hff};
                next_map[REGION_EXTENSION] = '{8'h50, 8'hff}; // sprite bank, input 3/4
                next_map[REGION_SCREEN0]   = '{8'h80, 8'hf0};
                next_map[REGION_OBJ]       = '{8'h90, 8'hff};
                next_map[REGION_PRIORITY]  = '{8'hb0, 8'hff};
            end
            GAME_FOOTCHMP: begin
                next_map[REGION_ROM]       = '{8'h00, 8'hf8};
                next_map[REGION_WORK_RAM]  = '{8'h10, 8'hff};
                next_map[REGION_OBJ]       = '{8'h20, 8'hff};
                next_map[REGION_EXTENSION] = '{8'h30, 8'hff};
                next_map[REGION_SCREEN1]   = '{8'h40, 8'hf0}; // scp ram and ctrl
                next_map[REGION_PRIORITY]  = '{8'h50, 8'hff};
                next_map[REGION_COLOR]     = '{8'h60, 8'hfe};
                next_map[REGION_IO0]       = '{8'h70, 8'hff}; // te7750
                next_map[REGION_SOUND]     = '{8'ha0, 8'hff};
            end
            GAME_YUYUGOGO: begin
                next_map[REGION_ROM]       = '{8'h00, 8'hfc};
                next_map[REGION_IO0]       = '{8'h20, 8'hff};
                next_map[REGION_SOUND]     = '{8'h40, 8'hff};
                next_map[REGION_SCREEN0]   = '{8'h80, 8'hf0};
                next_map[REGION_OBJ]       = '{8'h90, 8'hff};
                next_map[REGION_COLOR]     = '{8'ha0, 8'hfe};
                next_map[REGION_WORK_RAM]  = '{8'hb0, 8'hfe}; // b0 and b1
                next_map[REGION_EXTENSION] = '{8'hc0, 8'hf0};
                next_map[REGION_EXTRA_ROM] = '{8'hd0, 8'hf0}; // question data rom
            end
            GAME_PULIRULA: begin
                next_map[REGION_ROM]       = '{8'h00, 8'hf0};
                next_map[REGION_SOUND]     = '{8'h20, 8'hff};
                next_map[REGION_WORK_RAM]  = '{8'h30, 8'hff};
                next_map[REGION_ROZ]       = '{8'h40, 8'hf0}; // grw ram
                next_map[REGION_EXTENSION] = '{8'h60, 8'hff};
                next_map[REGION_COLOR]     = '{8'h70, 8'hf0};
                next_map[REGION_SCREEN0]   = '{8'h80, 8'hf0};
                next_map[REGION_OBJ]       = '{8'h90, 8'hff};
                next_map[REGION_PRIORITY]  = '{8'ha0, 8'hff};
                next_map[REGION_IO0]       = '{8'hb0, 8'hff};
            end
            GAME_METALB: begin
                next_map[REGION_ROM]       = '{8'h00, 8'hf0};
                next_map[REGION_WORK_RAM]  = '{8'h10, 8'hff};
                next_map[REGION_OBJ]       = '{8'h30, 8'hff};
                next_map[REGION_SCREEN1]   = '{8'h50, 8'hf0};
                next_map[REGION_PRIORITY]  = '{8'h60, 8'hff};
                next_map[REGION_COLOR]     = '{8'h70, 8'hff};
                next_map[REGION_IO0]       = '{8'h80, 8'hff};
                next_map[REGION_SOUND]     = '{8'h90, 8'hff};
            end
            GAME_DEADCONX,
            GAME_DEADCONXJ: begin
                next_map[REGION_ROM]       = '{8'h00, 8'hf0};
                next_map[REGION_WORK_RAM]  = '{8'h10, 8'hff};
                next_map[REGION_OBJ]       = '{8'h20, 8'hff};
                next_map[REGION_EXTENSION] = '{8'h30, 8'hff};
                next_map[REGION_SCREEN1]   = '{8'h40, 8'hf0};
                next_map[REGION_PRIORITY]  = '{8'h50, 8'hff};
                next_map[REGION_COLOR]     = '{8'h60, 8'hff};
                next_map[REGION_IO0]       = '{8'h70, 8'hff};
                next_map[REGION_SOUND]     = '{8'ha0, 8'hff};
            end
            GAME_DINOREX: begin
                next_map[REGION_ROM]       = '{8'h00, 8'he0}; // 2m
                next_map[REGION_ROM1]      = '{8'h20, 8'hf0}; // upper 1m
                next_map[REGION_IO0]       = '{8'h30, 8'hff};
                next_map[REGION_EXTENSION] = '{8'h40, 8'hff};
                next_map[REGION_COLOR]     = '{8'h50, 8'hff};
                next_map[REGION_WORK_RAM]  = '{8'h60, 8'hf0};
                next_map[REGION_PRIORITY]  = '{8'h70, 8'hff};
                next_map[REGION_OBJ]       = '{8'h80, 8'hff};
                next_map[REGION_SCREEN0]   = '{8'h90, 8'hf0};
                next_map[REGION_SOUND]     = '{8'ha0, 8'hff};
            end
            default: begin
                board_known = 1'b0; // keeps all unmapped
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            regions <= {REGION_COUNT{REGION_UNMAPPED}};
        end else begin
            regions <= next_map;
        end
    end

    // reset vector has to come from rom at address 0
    assert property (@(posedge clk)
        $fell(reset) && board_known |=> regions[REGION_ROM].base == 8'h00)
        else $error("rom base %h after reset", $sampled(regions[REGION_ROM].base));

endmodule

`default_nettype wire

// ==== test/tb_board_config.sv ====
`default_nettype none

module tb_board_config;

    import board_cfg_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int RANDOM_STEPS = 200;
    localparam int TOTAL_STEPS  = RESET_CYCLES + 8 * 2 + RANDOM_STEPS + 3 + 2;

    logic  clk;
    logic  reset;
    game_t game;
    logic  cfg_360pri, cfg_360pri_high, cfg_110pcr, cfg_260dar, cfg_260dar_acc;
    logic  cfg_190fmc, cfg_io_swap, cfg_tmp82c265, cfg_te7750, cfg_280grd;
    logic  cfg_430grw, cfg_480scp, cfg_100scn, cfg_bpp15, cfg_bppmix;
    logic [1:0]  cfg_obj_extender;
    logic [15:0] cfg_addr_rom, cfg_addr_rom1, cfg_addr_extra_rom, cfg_addr_work_ram;
    logic [15:0] cfg_addr_screen0, cfg_addr_screen1, cfg_addr_obj, cfg_addr_color;
    logic [15:0] cfg_addr_io0, cfg_addr_io1, cfg_addr_sound, cfg_addr_extension;
    logic [15:0] cfg_addr_priority, cfg_addr_roz, cfg_addr_cchip;

    feature_row_u      dut_flags;            // dut flag outputs regrouped
    logic [14:0][15:0] dut_map;              // index 0 is rom
    feature_row_u      exp_flags;
    logic [14:0][15:0] exp_map;
    game_t             last_game  = GAME_FINALB; // code seen at the previous edge
    logic              last_reset = 1'b1;
    logic              armed      = 1'b0;    // history valid
    logic              checked;
    logic              dcx_seen   = 1'b0;    // deadconx outputs captured
    logic              dcx_repeat;
    feature_row_u      dcx_flags;
    logic [14:0][15:0] dcx_map;
    logic [31:0]       rng        = 32'd782;

    game_t directed [8] = '{GAME_FINALB, GAME_GROWL, GAME_FOOTCHMP, GAME_PULIRULA,
                            GAME_DINOREX, GAME_YESNOJ, GAME_DEADCONX, GAME_DEADCONXJ};
    string region_names [15] = '{"cfg_addr_rom", "cfg_addr_rom1", "cfg_addr_extra_rom",
        "cfg_addr_work_ram", "cfg_addr_screen0", "cfg_addr_screen1", "cfg_addr_obj",
        "cfg_addr_color", "cfg_addr_io0", "cfg_addr_io1", "cfg_addr_sound",
        "cfg_addr_extension", "cfg_addr_priority", "cfg_addr_roz", "cfg_addr_cchip"};

    tb_clock u_clock (
        .clk   (clk),
        .reset (reset)
    );

    board_config u_dut (.*);

    assign dut_flags = {cfg_360pri_high, cfg_360pri, cfg_260dar_acc, cfg_260dar, cfg_110pcr,
                        cfg_190fmc, cfg_obj_extender, cfg_tmp82c265, cfg_te7750, cfg_io_swap,
                        cfg_280grd, cfg_430grw, cfg_480scp, cfg_100scn, cfg_bpp15, cfg_bppmix};
    assign dut_map = {cfg_addr_cchip, cfg_addr_roz, cfg_addr_priority, cfg_addr_extension,
                      cfg_addr_sound, cfg_addr_io1, cfg_addr_io0, cfg_addr_color, cfg_addr_obj,
                      cfg_addr_screen1, cfg_addr_screen0, cfg_addr_work_ram,
                      cfg_addr_extra_rom, cfg_addr_rom1, cfg_addr_rom};

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // boards with a row here, plus every code that has no row at all
    function automatic logic covered(input game_t g);
        case (g)
            GAME_DONDOKOD, GAME_MEGAB, GAME_THUNDFOX, GAME_CAMELTRY, GAME_YUYUGOGO,
            GAME_METALB, GAME_DEADCONX, GAME_DEADCONXJ: return 1'b0;
            default: return 1'b1;
        endcase
    endfunction

    function automatic feature_row_u expected_flags(input game_t g);
        feature_row_u f;
        case (g)
            GAME_FINALB:   f.fields = '{pcr: 1'b1, default: '0};
            GAME_GROWL:    f.fields = '{pri: 1'b1, dar: 1'b1, fmc: 1'b1, io_82c265: 1'b1,
                                        bpp15: 1'b1, bppmix: 1'b1, default: '0};
            GAME_FOOTCHMP: f.fields = '{pri: 1'b1, dar_acc: 1'b1, dar: 1'b1, fmc: 1'b1,
                                        io_te7750: 1'b1, scp: 1'b1, default: '0};
            GAME_PULIRULA: f.fields = '{pri_high: 1'b1, pri: 1'b1, dar: 1'b1,
                                        obj_extender: 2'd2, grw: 1'b1, bpp15: 1'b1,
                                        default: '0};
            GAME_DINOREX:  f.fields = '{pri: 1'b1, dar: 1'b1, obj_extender: 2'd1,
                                        bpp15: 1'b1, bppmix: 1'b1, default: '0};
            default:       f.fields = '{pcr: 1'b1, default: '0}; // palette chip only
        endcase
        return f;
    endfunction

    // entry order rom rom1 extra_rom work_ram screen0 | screen1 obj color io0 io1 |
    //        sound extension priority roz cchip
    function automatic logic [15:0] expected_entry(input game_t g, input int r);
        logic [15:0] m [15];
        case (g)
            GAME_FINALB:   m = '{16'h00fc, 16'hff00, 16'hff00, 16'h10ff, 16'h80f0,
                                 16'hff00, 16'h90ff, 16'h20ff, 16'h30ff, 16'hff00,
                                 16'h32ff, 16'hff00, 16'hff00, 16'hff00, 16'hff00};
            GAME_GROWL:    m = '{16'h00f0, 16'hff00, 16'hff00, 16'h10ff, 16'h80f0,
                                 16'hff00, 16'h90ff, 16'h20ff, 16'h30ff, 16'h32ff,
                                 16'h40ff, 16'h50ff, 16'hb0ff, 16'hff00, 16'hff00};
            GAME_FOOTCHMP: m = '{16'h00f8, 16'hff00, 16'hff00, 16'h10ff, 16'hff00,
                                 16'h40f0, 16'h20ff, 16'h60fe, 16'h70ff, 16'hff00,
                                 16'ha0ff, 16'h30ff, 16'h50ff, 16'hff00, 16'hff00};
            GAME_PULIRULA: m = '{16'h00f0, 16'hff00, 16'hff00, 16'h30ff, 16'h80f0,
                                 16'hff00, 16'h90ff, 16'h70f0, 16'hb0ff, 16'hff00,
                                 16'h20ff, 16'h60ff, 16'ha0ff, 16'h40f0, 16'hff00};
            GAME_DINOREX:  m = '{16'h00e0, 16'h20f0, 16'hff00, 16'h60f0, 16'h90f0,
                                 16'hff00, 16'h80ff, 16'h50ff, 16'h30ff, 16'hff00,
                                 16'ha0ff, 16'h40ff, 16'h70ff, 16'hff00, 16'hff00};
            default:       m = '{default: 16'hff00}; // nothing mapped
        endcase
        return m[r];
    endfunction

    task automatic stop_with_failure();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input string got, input string want);
        $display("FAILED %s: got 0x%s expected 0x%s", name, got, want);
        stop_with_failure();
    endtask

    task automatic apply_game(input game_t g, input int cycles);
        @(negedge clk);
        game = g;
        repeat (cycles - 1) @(negedge clk); // hold the code
    endtask

    always @(posedge clk) begin
        last_game  <= game;
        last_reset <= reset;
        armed      <= 1'b1;
        if (armed && !last_reset && last_game == GAME_DEADCONX) begin
            dcx_seen  <= 1'b1; // outputs now belong to deadconx
            dcx_flags <= dut_flags;
            dcx_map   <= dut_map;
        end
    end

    always_comb begin
        exp_flags = last_reset ? expected_flags(GAME_YESNOJ) : expected_flags(last_game);
        for (int r = 0; r < 15; r++) begin
            exp_map[r] = last_reset ? 16'hff00 : expected_entry(last_game, r);
        end
    end

    assign checked    = armed && (last_reset || covered(last_game));
    assign dcx_repeat = armed && !last_reset && dcx_seen && last_game == GAME_DEADCONXJ;

    assert property (@(posedge clk) checked |-> dut_flags == exp_flags)
        else report_mismatch("dut_flags", $sformatf("%h", $sampled(dut_flags)),
                             $sformatf("%h", $sampled(exp_flags)));

    for (genvar r = 0; r < 15; r++) begin : g_region_check
        assert property (@(posedge clk) checked |-> dut_map[r] == exp_map[r])
            else report_mismatch(region_names[r], $sformatf("%h", $sampled(dut_map[r])),
                                 $sformatf("%h", $sampled(exp_map[r])));
    end

    // deadconxj shares the deadconx board
    assert property (@(posedge clk) dcx_repeat |-> dut_flags == dcx_flags)
        else report_mismatch("dut_flags", $sformatf("%h", $sampled(dut_flags)),
                             $sformatf("%h", $sampled(dcx_flags)));
    assert property (@(posedge clk) dcx_repeat |-> dut_map == dcx_map)
        else report_mismatch("dut_map", $sformatf("%h", $sampled(dut_map)),
                             $sformatf("%h", $sampled(dcx_map)));

    initial begin
        game = GAME_GROWL; // must stay hidden while reset is high
        wait (reset == 1'b0);
        foreach (directed[i]) begin
            apply_game(directed[i], 2);
        end
        for (int i = 0; i < RANDOM_STEPS; i++) begin
            rng = xorshift32(rng);
            apply_game(game_t'(6'(rng % 32'd29)), 1);
        end
        apply_game(GAME_YESNOJ, 3); // lets the last codes reach the checks
        $display("sim passed");
        $finish;
    end

    initial begin
        #(TOTAL_STEPS * CLK_PERIOD + 400);
        $display("timeout: the stimulus did not finish in time");
        stop_with_failure();
    end

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // period 8
    end

    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk); // 16 cycles in reset
        @(negedge clk);
        reset = 1'b0; // released on a falling edge like every other input
    end

endmodule

`default_nettype wire
